/* list.f */
+incdir+source
source/des_pkg.sv
source/des_req_if.sv
source/des_wb_slave.sv
source/des_key_schedule.sv
source/des_round_engine.sv
source/cbc_chain.sv
source/des_cbc_dec_top.sv
tb/tb_des_checker.sv
tb/tb_des_cbc.sv

/* tb/tb_des_cbc.sv */
`include "des_params.svh"

module tb_des_cbc;
  import des_pkg::*;

  localparam int N_ROWS      = 20;
  localparam int ACK_TIMEOUT = 50;
  localparam int POLL_LIMIT  = 100;

  localparam des_block_t KEY_1 = 64'h1334_5779_9BBC_DFF1;
  localparam des_block_t CT_1  = 64'h85E8_1354_0F0A_B405;
  localparam des_block_t PT_1  = 64'h0123_4567_89AB_CDEF;
  localparam des_block_t KEY_2 = 64'h0E32_9232_EA6D_0D73;
  localparam des_block_t CT_2  = 64'h0000_0000_0000_0000;
  localparam des_block_t PT_2  = 64'h8787_8787_8787_8787;
  localparam des_block_t KEY_3 = 64'h0101_0101_0101_0101;
  localparam des_block_t CT_3  = 64'h8CA6_4DE9_C1B1_23A7;
  localparam des_block_t PT_3  = 64'h0000_0000_0000_0000;
  localparam des_block_t IV_A  = 64'hA5A5_5A5A_0F0F_F0F0;

  typedef enum {OP_STATUS, OP_KEY, OP_IV, OP_DEC, OP_DEC_BUSY} op_t;

  logic                      clk;
  logic                      arst_n;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [`DES_WB_ADDR_W-1:0] wb_adr;
  logic [`DES_WB_DATA_W-1:0] wb_dat_w;
  logic [`DES_WB_DATA_W-1:0] wb_dat_r;
  logic                      wb_ack;
  logic                      check_pt;
  logic                      check_status;
  des_block_t                exp_pt;
  logic [`DES_WB_DATA_W-1:0] exp_status;
  int                        failed_tests;

  op_t        row_op   [N_ROWS];
  des_block_t row_a    [N_ROWS];
  des_block_t row_b    [N_ROWS];
  des_block_t row_exp  [N_ROWS];
  string      row_name [N_ROWS];
  int         n_rows;

  des_cbc_dec_top u_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  tb_des_checker u_chk (
    .clk          (u_dut.clk),
    .arst_n       (u_dut.arst_n),
    .wb_cyc       (u_dut.wb_cyc),
    .wb_stb       (u_dut.wb_stb),
    .wb_we        (u_dut.wb_we),
    .wb_adr       (u_dut.wb_adr),
    .wb_dat_r     (u_dut.wb_dat_r),
    .wb_ack       (u_dut.wb_ack),
    .check_pt     (check_pt),
    .check_status (check_status),
    .exp_pt       (exp_pt),
    .exp_status   (exp_status),
    .failed_tests (failed_tests)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  task automatic abort_run(input string what);
    $display("ERROR at time %0t: %s", $time, what);
    $display("Testbench failed");
    $finish;
  endtask

  // one classic cycle, entered and left 2 time units after a rising edge
  task automatic bus_cycle(input logic we, input logic [`DES_WB_ADDR_W-1:0] adr,
                           input logic [`DES_WB_DATA_W-1:0] wdata,
                           output logic [`DES_WB_DATA_W-1:0] rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    @(negedge clk);
    while (!wb_ack)
    begin
      if (waited >= ACK_TIMEOUT)
      begin
        abort_run($sformatf("no ack for access to word %0d", adr));
      end
      @(negedge clk);
      waited++;
    end
    rdata = wb_dat_r;
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [`DES_WB_ADDR_W-1:0] adr,
                           input logic [`DES_WB_DATA_W-1:0] data);
    logic [`DES_WB_DATA_W-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input logic [`DES_WB_ADDR_W-1:0] adr,
                          output logic [`DES_WB_DATA_W-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic write_pair(input logic [`DES_WB_ADDR_W-1:0] hi_adr,
                            input logic [`DES_WB_ADDR_W-1:0] lo_adr, input des_block_t value);
    bus_write(hi_adr, value[63:32]);
    bus_write(lo_adr, value[31:0]);
  endtask

  task automatic wait_for_done(output logic saw_busy);
    logic [`DES_WB_DATA_W-1:0] status;
    int polls;
    saw_busy = 1'b0;
    polls    = 0;
    bus_read(`DES_REG_STATUS, status);
    while (!status[1])
    begin
      if (status[0])
      begin
        saw_busy = 1'b1;
      end
      if (polls >= POLL_LIMIT)
      begin
        abort_run("done bit in STATUS never set");
      end
      bus_read(`DES_REG_STATUS, status);
      polls++;
    end
  endtask

  task automatic check_plaintext(input des_block_t expected);
    logic [`DES_WB_DATA_W-1:0] data;
    exp_pt       = expected;
    exp_status   = 32'h0000_0002;
    check_pt     = 1'b1;
    check_status = 1'b1;
    bus_read(`DES_REG_PT_HI, data);
    bus_read(`DES_REG_PT_LO, data);
    bus_read(`DES_REG_STATUS, data);
    check_pt     = 1'b0;
    check_status = 1'b0;
  endtask

  task automatic add_row(input op_t op, input des_block_t a, input des_block_t b,
                         input des_block_t expected, input string name);
    row_op[n_rows]   = op;
    row_a[n_rows]    = a;
    row_b[n_rows]    = b;
    row_exp[n_rows]  = expected;
    row_name[n_rows] = name;
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    add_row(OP_STATUS, '0, '0, '0, "status after reset");
    add_row(OP_KEY, KEY_1, '0, '0, "");
    add_row(OP_IV, '0, '0, '0, "");
    add_row(OP_DEC, CT_1, '0, PT_1, "vector 1, zero iv");
    add_row(OP_KEY, KEY_2, '0, '0, "");
    add_row(OP_IV, '0, '0, '0, "");
    add_row(OP_DEC, CT_2, '0, PT_2, "vector 2, zero iv");
    add_row(OP_KEY, KEY_3, '0, '0, "");
    add_row(OP_IV, '0, '0, '0, "");
    add_row(OP_DEC, CT_3, '0, PT_3, "vector 3, zero iv");
    add_row(OP_KEY, KEY_1, '0, '0, "");
    add_row(OP_IV, IV_A, '0, '0, "");
    add_row(OP_DEC, CT_1, '0, PT_1 ^ IV_A, "iv xor");
    // chaining value is now the previous ciphertext
    add_row(OP_DEC, CT_1, '0, PT_1 ^ CT_1, "chained second block");
    add_row(OP_IV, IV_A, '0, '0, "");
    add_row(OP_DEC, CT_1, '0, PT_1 ^ IV_A, "iv reload");
    add_row(OP_IV, IV_A, '0, '0, "");
    add_row(OP_DEC_BUSY, CT_1, 64'h0000_0000_1111_2222, PT_1 ^ IV_A, "write while busy");
  endtask

  task automatic run_row(input int i);
    logic [`DES_WB_DATA_W-1:0] data;
    logic                      saw_busy;
    case (row_op[i])
      OP_STATUS:
      begin
        exp_status   = row_exp[i][31:0];
        check_status = 1'b1;
        bus_read(`DES_REG_STATUS, data);
        check_status = 1'b0;
        u_chk.close_test(row_name[i]);
      end
      OP_KEY:
      begin
        write_pair(`DES_REG_KEY_HI, `DES_REG_KEY_LO, row_a[i]);
      end
      OP_IV:
      begin
        write_pair(`DES_REG_IV_HI, `DES_REG_IV_LO, row_a[i]);
      end
      OP_DEC:
      begin
        write_pair(`DES_REG_CT_HI, `DES_REG_CT_LO, row_a[i]);
        wait_for_done(saw_busy);
        check_plaintext(row_exp[i]);
        u_chk.close_test(row_name[i]);
      end
      OP_DEC_BUSY:
      begin
        write_pair(`DES_REG_CT_HI, `DES_REG_CT_LO, row_a[i]);
        // lands while the engine is busy and must be dropped
        bus_write(`DES_REG_CT_LO, row_b[i][31:0]);
        wait_for_done(saw_busy);
        if (!saw_busy)
        begin
          u_chk.note_failure("STATUS never showed busy before done");
        end
        check_plaintext(row_exp[i]);
        u_chk.close_test(row_name[i]);
      end
      default: ;
    endcase
  endtask

  initial
  begin
    arst_n       = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    check_pt     = 1'b0;
    check_status = 1'b0;
    exp_pt       = '0;
    exp_status   = '0;
    build_table();
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    for (int i = 0; i < n_rows; i++)
    begin
      run_row(i);
    end
    u_chk.report_totals();
    if (failed_tests == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb/tb_des_checker.sv */
`include "des_params.svh"

module tb_des_checker (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`DES_WB_ADDR_W-1:0] wb_adr,
  input  logic [`DES_WB_DATA_W-1:0] wb_dat_r,
  input  logic                      wb_ack,
  input  logic                      check_pt,
  input  logic                      check_status,
  input  des_pkg::des_block_t       exp_pt,
  input  logic [`DES_WB_DATA_W-1:0] exp_status,
  output int                        failed_tests
);
  import des_pkg::*;

  int errors;
  int passed_tests;
  int mismatches;
  int test_index;

  initial
  begin
    errors       = 0;
    passed_tests = 0;
    failed_tests = 0;
    mismatches   = 0;
    test_index   = 0;
  end

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH at time %0t: %s expected %h actual %h", $time, name, expected, actual);
      errors++;
      mismatches++;
    end
  endtask

  // read data and ack are both stable by the falling edge
  always @(negedge clk)
  begin
    if (arst_n && wb_cyc && wb_stb && wb_ack && !wb_we)
    begin
      case (wb_adr)
        `DES_REG_PT_HI:
        begin
          if (check_pt)
          begin
            compare_word("PT_HI", exp_pt[63:32], wb_dat_r);
          end
        end
        `DES_REG_PT_LO:
        begin
          if (check_pt)
          begin
            compare_word("PT_LO", exp_pt[31:0], wb_dat_r);
          end
        end
        `DES_REG_STATUS:
        begin
          if (check_status)
          begin
            compare_word("STATUS", exp_status, wb_dat_r);
          end
        end
        default: ;
      endcase
    end
  end

  task automatic note_failure(input string what);
    $display("ERROR at time %0t: %s", $time, what);
    errors++;
  endtask

  task automatic close_test(input string name);
    test_index++;
    if (errors == 0)
    begin
      $display("test %0d %s: PASS", test_index, name);
      passed_tests++;
    end
    else
    begin
      $display("test %0d %s: FAIL with %0d error(s)", test_index, name, errors);
      failed_tests++;
    end
    errors = 0;
  endtask

  task automatic report_totals();
    $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
             test_index, passed_tests, failed_tests, mismatches);
  endtask

endmodule

/* source/des_cbc_dec_top.sv */
`include "des_params.svh"

module des_cbc_dec_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`DES_WB_ADDR_W-1:0] wb_adr,
  input  logic [`DES_WB_DATA_W-1:0] wb_dat_w,
  output logic [`DES_WB_DATA_W-1:0] wb_dat_r,
  output logic                      wb_ack
);
  import des_pkg::*;

  logic       iv_load;
  des_block_t iv;
  des_block_t plaintext;
  logic       done;
  logic       result_valid;
  des_block_t result;

  des_req_if req_if ();

  des_wb_slave u_wb_slave (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .req       (req_if.issuer),
    .iv_load   (iv_load),
    .iv        (iv),
    .plaintext (plaintext),
    .done      (done)
  );

  des_round_engine u_round_engine (
    .clk          (clk),
    .arst_n       (arst_n),
    .req          (req_if.engine),
    .result_valid (result_valid),
    .result       (result)
  );

  cbc_chain u_cbc_chain (
    .clk          (clk),
    .arst_n       (arst_n),
    .req          (req_if.chain),
    .iv_load      (iv_load),
    .iv           (iv),
    .result_valid (result_valid),
    .result       (result),
    .plaintext    (plaintext),
    .done         (done)
  );

endmodule

/* source/cbc_chain.sv */
module cbc_chain (
  input  logic                clk,
  input  logic                arst_n,
  des_req_if.chain            req,
  input  logic                iv_load,
  input  des_pkg::des_block_t iv,
  input  logic                result_valid,
  input  des_pkg::des_block_t result,
  output des_pkg::des_block_t plaintext,
  output logic                done
);
  import des_pkg::*;

  des_block_t ct_q;
  des_block_t chain_q;

  // ciphertext of the block in flight, next chaining value
  always_ff @(posedge clk)
  begin
    if (req.start)
    begin
      ct_q <= req.block;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      chain_q   <= '0;
      plaintext <= '0;
      done      <= 1'b0;
    end
    else if (result_valid)
    begin
      plaintext <= result ^ chain_q;
      chain_q   <= ct_q;
      done      <= 1'b1;
    end
    else
    begin
      if (iv_load)
      begin
        chain_q <= iv;
      end
      if (req.start)
      begin
        done <= 1'b0;
      end
    end
  end

endmodule

/* source/des_round_engine.sv */
`include "des_params.svh"

module des_round_engine (
  input  logic                clk,
  input  logic                arst_n,
  des_req_if.engine           req,
  output logic                result_valid,
  output des_pkg::des_block_t result
);
  import des_pkg::*;

  localparam int ROUND_W = $clog2(`DES_ROUNDS);
  localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(`DES_ROUNDS - 1);

  logic               busy_q;
  logic [ROUND_W-1:0] rnd_q;
  des_half_t          l_q;
  des_half_t          r_q;
  des_half_t          f_out;
  des_subkey_t        subkey;
  des_block_t         ip_out;

  des_key_schedule u_key_schedule (
    .clk     (clk),
    .arst_n  (arst_n),
    .load    (req.start),
    .key     (req.key),
    .advance (busy_q),
    .subkey  (subkey)
  );

  assign ip_out = permute(req.block, 64, IP_TABLE, 64);
  assign f_out  = feistel_f(r_q, subkey);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy_q       <= 1'b0;
      rnd_q        <= '0;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= 1'b0;
      if (req.start)
      begin
        busy_q <= 1'b1;
        rnd_q  <= '0;
      end
      else if (busy_q)
      begin
        rnd_q <= rnd_q + 1'b1;
        // last round written this cycle, result visible next
        if (rnd_q == LAST_ROUND)
        begin
          busy_q       <= 1'b0;
          result_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (req.start)
    begin
      {l_q, r_q} <= ip_out;
    end
    else if (busy_q)
    begin
      l_q <= r_q;
      r_q <= l_q ^ f_out;
    end
  end

  // halves swapped before the final permutation
  assign result   = permute({r_q, l_q}, 64, FP_TABLE, 64);
  assign req.busy = busy_q;

  a_valid_after_busy: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |-> $past(busy_q));

endmodule

/* source/des_key_schedule.sv */
`include "des_params.svh"

module des_key_schedule (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  load,
  input  des_pkg::des_block_t   key,
  input  logic                  advance,
  output des_pkg::des_subkey_t  subkey
);
  import des_pkg::*;

  localparam int ROUND_W = $clog2(`DES_ROUNDS);
  localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(`DES_ROUNDS - 1);

  logic [ROUND_W-1:0] idx_q;
  logic [1:0]         shift;
  des_cd_t            c_q;
  des_cd_t            d_q;
  des_block_t         pc1_out;
  des_block_t         pc2_out;

  function automatic des_cd_t rotr(des_cd_t v, logic [1:0] n);
    return (n == 2'd2) ? {v[1:0], v[27:2]} : {v[0], v[27:1]};
  endfunction

  // shifts walked backwards so the halves undo the encryption schedule
  assign shift   = SHIFT_TABLE[LAST_ROUND - idx_q];
  assign pc1_out = permute(key, 64, PC1_TABLE, 56);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      idx_q <= '0;
    end
    else if (load)
    begin
      idx_q <= '0;
    end
    else if (advance)
    begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // the full schedule rotates by 28, so pc1 alone already gives k16
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      c_q <= pc1_out[55:28];
      d_q <= pc1_out[27:0];
    end
    else if (advance)
    begin
      c_q <= rotr(c_q, shift);
      d_q <= rotr(d_q, shift);
    end
  end

  assign pc2_out = permute({8'b0, c_q, d_q}, 56, PC2_TABLE, 48);
  assign subkey  = pc2_out[47:0];

endmodule

/* source/des_wb_slave.sv */
`include "des_params.svh"

module des_wb_slave (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`DES_WB_ADDR_W-1:0] wb_adr,
  input  logic [`DES_WB_DATA_W-1:0] wb_dat_w,
  output logic [`DES_WB_DATA_W-1:0] wb_dat_r,
  output logic                      wb_ack,
  des_req_if.issuer                 req,
  output logic                      iv_load,
  output des_pkg::des_block_t       iv,
  input  des_pkg::des_block_t       plaintext,
  input  logic                      done
);
  import des_pkg::*;

  logic      wb_req;
  logic      wr_en;
  logic      start_q;
  des_half_t key_hi;
  des_half_t key_lo;
  des_half_t iv_hi;
  des_half_t iv_lo;
  des_half_t ct_hi;
  des_half_t ct_lo;

  assign wb_req = wb_cyc && wb_stb && !wb_ack;
  // every write is dropped while a block is in flight
  assign wr_en  = wb_req && wb_we && !req.busy;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wb_ack  <= 1'b0;
      start_q <= 1'b0;
      iv_load <= 1'b0;
    end
    else
    begin
      wb_ack  <= wb_req;
      start_q <= wr_en && (wb_adr == `DES_REG_CT_LO);
      iv_load <= wr_en && (wb_adr == `DES_REG_IV_LO);
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      case (wb_adr)
        `DES_REG_KEY_HI: key_hi <= wb_dat_w;
        `DES_REG_KEY_LO: key_lo <= wb_dat_w;
        `DES_REG_IV_HI:  iv_hi  <= wb_dat_w;
        `DES_REG_IV_LO:  iv_lo  <= wb_dat_w;
        `DES_REG_CT_HI:  ct_hi  <= wb_dat_w;
        `DES_REG_CT_LO:  ct_lo  <= wb_dat_w;
        default: ;
      endcase
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk)
  begin
    if (wb_req && !wb_we)
    begin
      case (wb_adr)
        `DES_REG_PT_HI:  wb_dat_r <= plaintext[63:32];
        `DES_REG_PT_LO:  wb_dat_r <= plaintext[31:0];
        `DES_REG_STATUS: wb_dat_r <= {{(`DES_WB_DATA_W - 2){1'b0}}, done, req.busy};
        default:         wb_dat_r <= '0;
      endcase
    end
  end

  assign req.start = start_q;
  assign req.key   = {key_hi, key_lo};
  assign req.block = {ct_hi, ct_lo};
  assign iv        = {iv_hi, iv_lo};

  a_ack_single: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack);

  // engine must be idle whenever a new block is launched
  a_start_idle: assert property (@(posedge clk) disable iff (!arst_n) req.start |-> !req.busy);

endmodule

/* source/des_req_if.sv */
interface des_req_if;
  import des_pkg::*;

  logic       start;
  des_block_t key;
  des_block_t block;
  logic       busy;

  modport issuer (
    output start,
    output key,
    output block,
    input  busy
  );

  modport engine (
    input  start,
    input  key,
    input  block,
    output busy
  );

  // chain only needs the ciphertext at start
  modport chain (
    input start,
    input block
  );

endinterface

/* source/des_pkg.sv */
package des_pkg;

  typedef logic [63:0] des_block_t;
  typedef logic [31:0] des_half_t;
  typedef logic [47:0] des_subkey_t;
  typedef logic [27:0] des_cd_t;

  // tables are 1-based with bit 1 as the msb, unused tail entries are zero
  typedef byte unsigned perm_tbl_t [64];
  typedef logic [3:0] sbox_tbl_t [8][4][16];

  localparam perm_tbl_t IP_TABLE = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

  localparam perm_tbl_t FP_TABLE = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};

  localparam perm_tbl_t E_TABLE = '{
    32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1,
    0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};

  localparam perm_tbl_t P_TABLE = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
    2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25,
    0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
    0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};

  localparam perm_tbl_t PC1_TABLE = '{
    57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18, 10, 2,
    59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36, 63, 55, 47, 39,
    31, 23, 15, 7, 62, 54, 46, 38, 30, 22, 14, 6, 61, 53, 45, 37,
    29, 21, 13, 5, 28, 20, 12, 4, 0, 0, 0, 0, 0, 0, 0, 0};

  localparam perm_tbl_t PC2_TABLE = '{
    14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
    26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32,
    0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};

  // left rotations per encryption round
  localparam logic [1:0] SHIFT_TABLE [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

  localparam sbox_tbl_t SBOX_TABLE = '{
    '{'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7},
      '{0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8},
      '{4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0},
      '{15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13}},
    '{'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10},
      '{3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5},
      '{0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15},
      '{13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9}},
    '{'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8},
      '{13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1},
      '{13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7},
      '{1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12}},
    '{'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15},
      '{13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9},
      '{10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4},
      '{3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14}},
    '{'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9},
      '{14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6},
      '{4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14},
      '{11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3}},
    '{'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11},
      '{10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8},
      '{9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6},
      '{4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13}},
    '{'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1},
      '{13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6},
      '{1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2},
      '{6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12}},
    '{'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7},
      '{1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2},
      '{7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8},
      '{2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}}};

  // in_w-bit value in din[in_w-1:0] to out_w-bit value in the low bits of the result
  function automatic des_block_t permute(des_block_t din, int in_w, perm_tbl_t tbl, int out_w);
    des_block_t dout;
    dout = '0;
    for (int i = 0; i < 64; i++)
    begin
      if (i < out_w)
      begin
        dout[out_w - 1 - i] = din[in_w - tbl[i]];
      end
    end
    return dout;
  endfunction

  function automatic des_half_t feistel_f(des_half_t r, des_subkey_t k);
    des_block_t t;
    des_subkey_t x;
    des_half_t s;
    logic [5:0] b;
    t = permute({32'b0, r}, 32, E_TABLE, 48);
    x = t[47:0] ^ k;
    for (int i = 0; i < 8; i++)
    begin
      // outer bits pick the row, inner four the column
      b = x[47 - 6 * i -: 6];
      s[31 - 4 * i -: 4] = SBOX_TABLE[i][{b[5], b[0]}][b[4:1]];
    end
    t = permute({32'b0, s}, 32, P_TABLE, 32);
    return t[31:0];
  endfunction

endpackage

/* source/des_params.svh */
`ifndef DES_PARAMS_SVH
`define DES_PARAMS_SVH

// bus geometry
`define DES_WB_ADDR_W 4
`define DES_WB_DATA_W 32

`define DES_ROUNDS 16

// register word addresses, _HI holds bits 63..32
`define DES_REG_KEY_HI 4'd0
`define DES_REG_KEY_LO 4'd1
`define DES_REG_IV_HI  4'd2
`define DES_REG_IV_LO  4'd3
`define DES_REG_CT_HI  4'd4
`define DES_REG_CT_LO  4'd5
`define DES_REG_PT_HI  4'd6
`define DES_REG_PT_LO  4'd7
`define DES_REG_STATUS 4'd8

`endif
